// File: src/cache_pkg.sv
package cache_pkg;

    // ********************
    // Command encoding
    // ********************

    // Commands issued by the requester on the op input.
    typedef enum logic [1:0] {
        OP_READ  = 2'd0,
        OP_WRITE = 2'd1,
        OP_FILL  = 2'd2
    } op_e;

    // ********************
    // Data word geometry
    // ********************

    // Bytes in one data word; the byte mask has one bit per byte.
    localparam int WORD_BYTES = 4;

endpackage

// File: src/cache_array.sv
`timescale 1ns/1ps

module cache_array #(
    parameter type payload_t = logic,
    parameter int  LANES     = 1,
    parameter int  DEPTH     = 64
) (
    input  logic                     clk,
    input  logic [LANES-1:0]         wen,
    input  logic [$clog2(DEPTH)-1:0] addr,
    input  payload_t                 data_in,
    output payload_t                 data_out
);

    localparam int WIDTH  = $bits(payload_t);
    localparam int LANE_W = WIDTH / LANES;
    localparam int AW     = $clog2(DEPTH);

    logic [LANES-1:0] wen_q;
    logic [AW-1:0]    addr_q;
    logic [WIDTH-1:0] data_q;
    logic [WIDTH-1:0] mem [DEPTH];

    // Storage starts out all zero, so every entry is invalid and clean.
    initial begin
        for (int i = 0; i < DEPTH; i++) begin
            mem[i] = '0;
        end
    end

    // Input stage.
    always_ff @(posedge clk) begin
        wen_q  <= wen;
        addr_q <= addr;
        data_q <= data_in;
    end

    // Each lane is written on its own enable at the registered address.
    always @(posedge clk) begin
        for (int l = 0; l < LANES; l++) begin
            if (wen_q[l]) begin
                mem[addr_q][l*LANE_W +: LANE_W] <= data_q[l*LANE_W +: LANE_W];
            end
        end
    end

    // Read port follows the registered address.
    assign data_out = mem[addr_q];

endmodule

// File: src/cache_decode.sv
`timescale 1ns/1ps

module cache_decode #(
    parameter int  ADDR_WIDTH = 32,
    parameter int  SETS       = 64,
    parameter int  LINE_WORDS = 16,
    localparam int BYTE_W     = $clog2(cache_pkg::WORD_BYTES),
    localparam int OFFSET_W   = $clog2(LINE_WORDS),
    localparam int INDEX_W    = $clog2(SETS),
    localparam int TAG_W      = ADDR_WIDTH - INDEX_W - OFFSET_W - BYTE_W,
    localparam int WORD_BITS  = cache_pkg::WORD_BYTES * 8
) (
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic                             req,
    input  cache_pkg::op_e                   op,
    input  logic [ADDR_WIDTH-1:0]            addr,
    input  logic [WORD_BITS-1:0]             wdata,
    input  logic [cache_pkg::WORD_BYTES-1:0] wmask,
    output logic                             ready,
    output logic                             req_fire,
    output cache_pkg::op_e                   req_op,
    output logic [INDEX_W-1:0]               req_index,
    output logic [TAG_W-1:0]                 req_tag,
    output logic                             stage_valid,
    output cache_pkg::op_e                   stage_op,
    output logic [TAG_W-1:0]                 stage_tag,
    output logic [INDEX_W-1:0]               stage_index,
    output logic [OFFSET_W-1:0]              stage_offset,
    output logic [WORD_BITS-1:0]             stage_wdata,
    output logic [cache_pkg::WORD_BYTES-1:0] stage_mask
);

    logic [OFFSET_W-1:0] req_offset;

    // The address splits into tag, index, word offset and byte in word.
    assign req_offset = addr[BYTE_W +: OFFSET_W];
    assign req_index  = addr[BYTE_W+OFFSET_W +: INDEX_W];
    assign req_tag    = addr[ADDR_WIDTH-1 -: TAG_W];
    assign req_op     = op;
    assign req_fire   = req && ready;

    // A write holds off the next command for its commit cycle.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ready       <= 1'b1;
            stage_valid <= 1'b0;
        end else begin
            ready       <= !(req_fire && (op == cache_pkg::OP_WRITE));
            stage_valid <= req_fire;
        end
    end

    // Fields held for the cycle in which the arrays answer.
    always_ff @(posedge clk) begin
        if (req_fire) begin
            stage_op     <= op;
            stage_tag    <= req_tag;
            stage_index  <= req_index;
            stage_offset <= req_offset;
            stage_wdata  <= wdata;
            stage_mask   <= wmask;
        end
    end

endmodule

// File: src/cache_execute.sv
`timescale 1ns/1ps

module cache_execute #(
    parameter int  ADDR_WIDTH = 32,
    parameter int  SETS       = 64,
    parameter int  LINE_WORDS = 16,
    localparam int BYTE_W     = $clog2(cache_pkg::WORD_BYTES),
    localparam int OFFSET_W   = $clog2(LINE_WORDS),
    localparam int INDEX_W    = $clog2(SETS),
    localparam int TAG_W      = ADDR_WIDTH - INDEX_W - OFFSET_W - BYTE_W,
    localparam int WORD_BITS  = cache_pkg::WORD_BYTES * 8,
    localparam int LANES      = LINE_WORDS * cache_pkg::WORD_BYTES,
    localparam int LINE_BITS  = LINE_WORDS * WORD_BITS
) (
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic                             req_fire,
    input  cache_pkg::op_e                   req_op,
    input  logic [INDEX_W-1:0]               req_index,
    input  logic [TAG_W-1:0]                 req_tag,
    input  logic [LINE_BITS-1:0]             fill_line,
    input  logic [TAG_W-1:0]                 stage_tag,
    input  logic [OFFSET_W-1:0]              stage_offset,
    input  logic [WORD_BITS-1:0]             stage_wdata,
    input  logic [cache_pkg::WORD_BYTES-1:0] stage_mask,
    input  logic [TAG_W:0]                   tag_rd,
    output logic [INDEX_W-1:0]               tag_addr,
    output logic                             tag_wen,
    output logic [TAG_W:0]                   tag_wr,
    output logic [INDEX_W-1:0]               data_addr,
    output logic [LANES-1:0]                 data_wen,
    output logic [LINE_BITS-1:0]             data_wr,
    output logic [INDEX_W-1:0]               dirty_addr,
    output logic                             dirty_wen,
    output logic                             dirty_wr,
    output logic                             line_hit
);

    logic               fill_fire;
    logic               commit_pend;
    logic [INDEX_W-1:0] commit_index;
    logic [INDEX_W-1:0] array_addr;
    logic [LANES-1:0]   commit_lanes;

    // ********************
    // Commit state
    // ********************

    // Set for the one cycle after a write is accepted.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            commit_pend <= 1'b0;
        end else begin
            commit_pend <= req_fire && (req_op == cache_pkg::OP_WRITE);
        end
    end

    always_ff @(posedge clk) begin
        if (req_fire) begin
            commit_index <= req_index;
        end
    end

    // ********************
    // Lookup
    // ********************

    // Bit TAG_W of an entry is its valid flag.
    assign line_hit = tag_rd[TAG_W] && (tag_rd[TAG_W-1:0] == stage_tag);

    assign fill_fire = req_fire && (req_op == cache_pkg::OP_FILL);

    // Byte enables of the addressed word within the line.
    assign commit_lanes = {{(LANES-cache_pkg::WORD_BYTES){1'b0}}, stage_mask}
                          << (stage_offset * cache_pkg::WORD_BYTES);

    // ********************
    // Array ports
    // ********************

    // The commit cycle owns the arrays; no request can fire in it.
    assign array_addr = commit_pend ? commit_index : req_index;
    assign tag_addr   = array_addr;
    assign data_addr  = array_addr;
    assign dirty_addr = array_addr;

    // Only a fill installs a tag.
    assign tag_wen = fill_fire;
    assign tag_wr  = {1'b1, req_tag};

    always_comb begin
        if (commit_pend) begin
            data_wen = line_hit ? commit_lanes : '0;
            data_wr  = {LINE_WORDS{stage_wdata}};
        end else begin
            data_wen = fill_fire ? '1 : '0;
            data_wr  = fill_line;
        end
    end

    // A write hit marks the line dirty, a fill cleans it.
    assign dirty_wen = commit_pend ? line_hit : fill_fire;
    assign dirty_wr  = commit_pend;

endmodule

// File: src/cache_result.sv
`timescale 1ns/1ps

module cache_result #(
    parameter int  ADDR_WIDTH = 32,
    parameter int  SETS       = 64,
    parameter int  LINE_WORDS = 16,
    localparam int BYTE_W     = $clog2(cache_pkg::WORD_BYTES),
    localparam int OFFSET_W   = $clog2(LINE_WORDS),
    localparam int INDEX_W    = $clog2(SETS),
    localparam int TAG_W      = ADDR_WIDTH - INDEX_W - OFFSET_W - BYTE_W,
    localparam int WORD_BITS  = cache_pkg::WORD_BYTES * 8,
    localparam int LINE_BITS  = LINE_WORDS * WORD_BITS
) (
    input  logic                  stage_valid,
    input  cache_pkg::op_e        stage_op,
    input  logic [INDEX_W-1:0]    stage_index,
    input  logic [OFFSET_W-1:0]   stage_offset,
    input  logic                  line_hit,
    input  logic [TAG_W:0]        tag_rd,
    input  logic                  dirty_rd,
    input  logic [LINE_BITS-1:0]  line_rd,
    output logic                  resp_valid,
    output logic                  hit,
    output logic [WORD_BITS-1:0]  rdata,
    output logic                  victim_valid,
    output logic                  victim_dirty,
    output logic [ADDR_WIDTH-1:0] victim_addr
);

    logic is_fill;
    logic old_valid;

    assign is_fill   = stage_valid && (stage_op == cache_pkg::OP_FILL);
    assign old_valid = tag_rd[TAG_W];

    // Every accepted command answers in the following cycle.
    assign resp_valid = stage_valid;
    assign hit        = stage_valid && line_hit;

    // Same word select for a read hit and for the evicted line of a fill.
    assign rdata = line_rd[stage_offset*WORD_BITS +: WORD_BITS];

    // Victim is the line still held at the index before the fill lands.
    assign victim_valid = is_fill && old_valid;
    assign victim_dirty = is_fill && old_valid && dirty_rd;

    // Line aligned, so the offset and byte bits are zero.
    assign victim_addr = {tag_rd[TAG_W-1:0], stage_index, {(OFFSET_W+BYTE_W){1'b0}}};

endmodule

// File: src/cache_core.sv
`timescale 1ns/1ps

module cache_core #(
    parameter int ADDR_WIDTH = 32,
    parameter int SETS       = 64,
    parameter int LINE_WORDS = 16
) (
    input  logic                                          clk,
    input  logic                                          rst_n,
    input  logic                                          req,
    input  cache_pkg::op_e                                op,
    input  logic [ADDR_WIDTH-1:0]                         addr,
    input  logic [cache_pkg::WORD_BYTES*8-1:0]            wdata,
    input  logic [cache_pkg::WORD_BYTES-1:0]              wmask,
    input  logic [LINE_WORDS*cache_pkg::WORD_BYTES*8-1:0] fill_line,
    output logic                                          ready,
    output logic                                          resp_valid,
    output logic                                          hit,
    output logic [cache_pkg::WORD_BYTES*8-1:0]            rdata,
    output logic                                          victim_valid,
    output logic                                          victim_dirty,
    output logic [ADDR_WIDTH-1:0]                         victim_addr
);

    localparam int BYTE_W    = $clog2(cache_pkg::WORD_BYTES);
    localparam int OFFSET_W  = $clog2(LINE_WORDS);
    localparam int INDEX_W   = $clog2(SETS);
    localparam int TAG_W     = ADDR_WIDTH - INDEX_W - OFFSET_W - BYTE_W;
    localparam int WORD_BITS = cache_pkg::WORD_BYTES * 8;
    localparam int LANES     = LINE_WORDS * cache_pkg::WORD_BYTES;
    localparam int LINE_BITS = LINE_WORDS * WORD_BITS;

    // Valid flag on top of the tag.
    typedef logic [TAG_W:0]       tag_entry_t;
    typedef logic [LINE_BITS-1:0] line_t;

    logic                             req_fire;
    cache_pkg::op_e                   req_op;
    logic [INDEX_W-1:0]               req_index;
    logic [TAG_W-1:0]                 req_tag;
    logic                             stage_valid;
    cache_pkg::op_e                   stage_op;
    logic [TAG_W-1:0]                 stage_tag;
    logic [INDEX_W-1:0]               stage_index;
    logic [OFFSET_W-1:0]              stage_offset;
    logic [WORD_BITS-1:0]             stage_wdata;
    logic [cache_pkg::WORD_BYTES-1:0] stage_mask;
    logic                             line_hit;

    logic [INDEX_W-1:0] tag_addr;
    logic [INDEX_W-1:0] data_addr;
    logic [INDEX_W-1:0] dirty_addr;
    logic               tag_wen;
    logic [LANES-1:0]   data_wen;
    logic               dirty_wen;
    tag_entry_t         tag_wr;
    tag_entry_t         tag_rd;
    line_t              data_wr;
    line_t              line_rd;
    logic               dirty_wr;
    logic               dirty_rd;

    // ********************
    // Pipeline
    // ********************

    cache_decode #(
        .ADDR_WIDTH (ADDR_WIDTH),
        .SETS       (SETS),
        .LINE_WORDS (LINE_WORDS)
    ) u_decode (
        .clk          (clk),
        .rst_n        (rst_n),
        .req          (req),
        .op           (op),
        .addr         (addr),
        .wdata        (wdata),
        .wmask        (wmask),
        .ready        (ready),
        .req_fire     (req_fire),
        .req_op       (req_op),
        .req_index    (req_index),
        .req_tag      (req_tag),
        .stage_valid  (stage_valid),
        .stage_op     (stage_op),
        .stage_tag    (stage_tag),
        .stage_index  (stage_index),
        .stage_offset (stage_offset),
        .stage_wdata  (stage_wdata),
        .stage_mask   (stage_mask)
    );

    cache_execute #(
        .ADDR_WIDTH (ADDR_WIDTH),
        .SETS       (SETS),
        .LINE_WORDS (LINE_WORDS)
    ) u_execute (
        .clk          (clk),
        .rst_n        (rst_n),
        .req_fire     (req_fire),
        .req_op       (req_op),
        .req_index    (req_index),
        .req_tag      (req_tag),
        .fill_line    (fill_line),
        .stage_tag    (stage_tag),
        .stage_offset (stage_offset),
        .stage_wdata  (stage_wdata),
        .stage_mask   (stage_mask),
        .tag_rd       (tag_rd),
        .tag_addr     (tag_addr),
        .tag_wen      (tag_wen),
        .tag_wr       (tag_wr),
        .data_addr    (data_addr),
        .data_wen     (data_wen),
        .data_wr      (data_wr),
        .dirty_addr   (dirty_addr),
        .dirty_wen    (dirty_wen),
        .dirty_wr     (dirty_wr),
        .line_hit     (line_hit)
    );

    cache_result #(
        .ADDR_WIDTH (ADDR_WIDTH),
        .SETS       (SETS),
        .LINE_WORDS (LINE_WORDS)
    ) u_result (
        .stage_valid  (stage_valid),
        .stage_op     (stage_op),
        .stage_index  (stage_index),
        .stage_offset (stage_offset),
        .line_hit     (line_hit),
        .tag_rd       (tag_rd),
        .dirty_rd     (dirty_rd),
        .line_rd      (line_rd),
        .resp_valid   (resp_valid),
        .hit          (hit),
        .rdata        (rdata),
        .victim_valid (victim_valid),
        .victim_dirty (victim_dirty),
        .victim_addr  (victim_addr)
    );

    // ********************
    // Storage
    // ********************

    cache_array #(
        .payload_t (tag_entry_t),
        .LANES     (1),
        .DEPTH     (SETS)
    ) tag_array (
        .clk      (clk),
        .wen      (tag_wen),
        .addr     (tag_addr),
        .data_in  (tag_wr),
        .data_out (tag_rd)
    );

    // One write lane per byte of the line.
    cache_array #(
        .payload_t (line_t),
        .LANES     (LANES),
        .DEPTH     (SETS)
    ) data_array (
        .clk      (clk),
        .wen      (data_wen),
        .addr     (data_addr),
        .data_in  (data_wr),
        .data_out (line_rd)
    );

    cache_array #(
        .payload_t (logic),
        .LANES     (1),
        .DEPTH     (SETS)
    ) dirty_array (
        .clk      (clk),
        .wen      (dirty_wen),
        .addr     (dirty_addr),
        .data_in  (dirty_wr),
        .data_out (dirty_rd)
    );

endmodule

// File: sim/cache_assert.sv
`timescale 1ns/1ps

module cache_assert (
    input logic           clk,
    input logic           rst_n,
    input logic           req,
    input cache_pkg::op_e op,
    input logic           ready,
    input logic           resp_valid
);

    logic accept;
    logic accept_write;

    assign accept       = req && ready;
    assign accept_write = accept && (op == cache_pkg::OP_WRITE);

    // ********************
    // Response timing
    // ********************

    resp_after_accept: assert property (@(posedge clk) disable iff (!rst_n)
        accept |=> resp_valid)
        else $error("resp_valid missing in the cycle after an accepted command");

    resp_needs_accept: assert property (@(posedge clk) disable iff (!rst_n)
        resp_valid |-> $past(accept))
        else $error("resp_valid without an accepted command one cycle before");

    // ********************
    // Write stall
    // ********************

    write_stalls_once: assert property (@(posedge clk) disable iff (!rst_n)
        accept_write |=> !ready ##1 ready)
        else $error("ready not low for exactly one cycle after a write");

    stall_after_write: assert property (@(posedge clk) disable iff (!rst_n)
        !ready |-> $past(accept_write))
        else $error("ready low without a write accepted one cycle before");

    reset_state: assert property (@(posedge clk)
        !rst_n |=> ready && !resp_valid)
        else $error("ready or resp_valid wrong after a reset cycle");

endmodule

bind cache_core cache_assert u_cache_assert (
    .clk        (clk),
    .rst_n      (rst_n),
    .req        (req),
    .op         (op),
    .ready      (ready),
    .resp_valid (resp_valid)
);

// File: sim/cache_checker.sv
`timescale 1ns/1ps

module cache_checker #(
    parameter int ADDR_WIDTH = 32
) (
    input  logic                               clk,
    input  logic                               rst_n,
    input  logic                               req,
    input  logic                               ready,
    input  logic                               resp_valid,
    input  logic                               hit,
    input  logic [cache_pkg::WORD_BYTES*8-1:0] rdata,
    input  logic                               victim_valid,
    input  logic                               victim_dirty,
    input  logic [ADDR_WIDTH-1:0]              victim_addr,
    input  cache_pkg::op_e                     exp_op,
    input  logic [ADDR_WIDTH-1:0]              exp_addr,
    input  logic                               exp_hit,
    input  logic [cache_pkg::WORD_BYTES*8-1:0] exp_data,
    input  logic                               exp_vvalid,
    input  logic                               exp_vdirty,
    input  logic [ADDR_WIDTH-1:0]              exp_vaddr,
    output int                                 pass_count,
    output int                                 fail_count,
    output int                                 resp_count
);

    localparam int WORD_BITS = cache_pkg::WORD_BYTES * 8;

    typedef struct packed {
        cache_pkg::op_e        op;
        logic [ADDR_WIDTH-1:0] addr;
        logic                  hit;
        logic [WORD_BITS-1:0]  data;
        logic                  vvalid;
        logic                  vdirty;
        logic [ADDR_WIDTH-1:0] vaddr;
    } expect_t;

    expect_t pending[$];
    expect_t head;

    initial begin
        pass_count = 0;
        fail_count = 0;
        resp_count = 0;
    end

    function automatic string op_name(input cache_pkg::op_e o);
        case (o)
            cache_pkg::OP_READ:  return "read";
            cache_pkg::OP_WRITE: return "write";
            cache_pkg::OP_FILL:  return "fill";
            default:             return "unknown";
        endcase
    endfunction

    task automatic mismatch(input string what, input logic [ADDR_WIDTH-1:0] got,
                            input logic [ADDR_WIDTH-1:0] want);
        $display("[ERROR] %0t: test %0d %s is %h, expected %h", $time, resp_count, what,
                 got, want);
    endtask

    // Hit is not defined for fills; rdata only where it carries a word.
    task automatic check_response(input expect_t e);
        int errs;
        errs = 0;
        if (e.op != cache_pkg::OP_FILL && hit !== e.hit) begin
            mismatch("hit", ADDR_WIDTH'(hit), ADDR_WIDTH'(e.hit));
            errs++;
        end
        if (e.op == cache_pkg::OP_READ && e.hit && rdata !== e.data) begin
            mismatch("rdata", ADDR_WIDTH'(rdata), ADDR_WIDTH'(e.data));
            errs++;
        end
        if (e.op == cache_pkg::OP_FILL) begin
            if (victim_valid !== e.vvalid) begin
                mismatch("victim_valid", ADDR_WIDTH'(victim_valid), ADDR_WIDTH'(e.vvalid));
                errs++;
            end else if (e.vvalid) begin
                if (victim_dirty !== e.vdirty) begin
                    mismatch("victim_dirty", ADDR_WIDTH'(victim_dirty), ADDR_WIDTH'(e.vdirty));
                    errs++;
                end
                if (victim_addr !== e.vaddr) begin
                    mismatch("victim_addr", victim_addr, e.vaddr);
                    errs++;
                end
                if (rdata !== e.data) begin
                    mismatch("evicted word", ADDR_WIDTH'(rdata), ADDR_WIDTH'(e.data));
                    errs++;
                end
            end
        end
        if (errs == 0) begin
            pass_count++;
            $display("test %0d %s %h: ok", resp_count, op_name(e.op), e.addr);
        end else begin
            fail_count++;
            $display("test %0d %s %h: FAILED", resp_count, op_name(e.op), e.addr);
        end
    endtask

    // Inputs change just after the rising edge, so the falling edge sees them settled.
    always @(negedge clk) begin
        if (rst_n && resp_valid) begin
            resp_count++;
            if (pending.size() == 0) begin
                $display("A response came at %0t with no command outstanding", $time);
                fail_count++;
            end else begin
                head = pending.pop_front();
                check_response(head);
            end
        end
        if (rst_n && req && ready) begin
            pending.push_back({exp_op, exp_addr, exp_hit, exp_data, exp_vvalid, exp_vdirty,
                               exp_vaddr});
        end
    end

endmodule

// File: sim/tb_cache.sv
`timescale 1ns/1ps

module tb_cache;

    localparam int ADDR_WIDTH   = 32;
    localparam int SETS         = 64;
    localparam int LINE_WORDS   = 16;
    localparam int WORD_BITS    = cache_pkg::WORD_BYTES * 8;
    localparam int LINE_BITS    = LINE_WORDS * WORD_BITS;
    localparam int RESET_CYCLES = 10;

    typedef struct packed {
        cache_pkg::op_e                   op;
        logic [ADDR_WIDTH-1:0]            addr;
        logic [WORD_BITS-1:0]             wdata;
        logic [cache_pkg::WORD_BYTES-1:0] mask;
        logic                             hit;
        logic [WORD_BITS-1:0]             rdata;
        logic                             vvalid;
        logic                             vdirty;
        logic [ADDR_WIDTH-1:0]            vaddr;
    } test_t;

    logic                             clk;
    logic                             rst_n;
    logic                             req;
    cache_pkg::op_e                   op;
    logic [ADDR_WIDTH-1:0]            addr;
    logic [WORD_BITS-1:0]             wdata;
    logic [cache_pkg::WORD_BYTES-1:0] wmask;
    logic [LINE_BITS-1:0]             fill_line;
    logic                             ready;
    logic                             resp_valid;
    logic                             hit;
    logic [WORD_BITS-1:0]             rdata;
    logic                             victim_valid;
    logic                             victim_dirty;
    logic [ADDR_WIDTH-1:0]            victim_addr;

    // Expected fields travel beside the command.
    cache_pkg::op_e                   exp_op;
    logic [ADDR_WIDTH-1:0]            exp_addr;
    logic                             exp_hit;
    logic [WORD_BITS-1:0]             exp_data;
    logic                             exp_vvalid;
    logic                             exp_vdirty;
    logic [ADDR_WIDTH-1:0]            exp_vaddr;

    int    pass_count;
    int    fail_count;
    int    resp_count;
    int    cycle_count;
    int    cycle_limit;
    bit    load_error;
    test_t tests[$];

    cache_core #(
        .ADDR_WIDTH (ADDR_WIDTH),
        .SETS       (SETS),
        .LINE_WORDS (LINE_WORDS)
    ) dut (
        .clk          (clk),
        .rst_n        (rst_n),
        .req          (req),
        .op           (op),
        .addr         (addr),
        .wdata        (wdata),
        .wmask        (wmask),
        .fill_line    (fill_line),
        .ready        (ready),
        .resp_valid   (resp_valid),
        .hit          (hit),
        .rdata        (rdata),
        .victim_valid (victim_valid),
        .victim_dirty (victim_dirty),
        .victim_addr  (victim_addr)
    );

    cache_checker #(
        .ADDR_WIDTH (ADDR_WIDTH)
    ) u_checker (
        .clk          (clk),
        .rst_n        (rst_n),
        .req          (req),
        .ready        (ready),
        .resp_valid   (resp_valid),
        .hit          (hit),
        .rdata        (rdata),
        .victim_valid (victim_valid),
        .victim_dirty (victim_dirty),
        .victim_addr  (victim_addr),
        .exp_op       (exp_op),
        .exp_addr     (exp_addr),
        .exp_hit      (exp_hit),
        .exp_data     (exp_data),
        .exp_vvalid   (exp_vvalid),
        .exp_vdirty   (exp_vdirty),
        .exp_vaddr    (exp_vaddr),
        .pass_count   (pass_count),
        .fail_count   (fail_count),
        .resp_count   (resp_count)
    );

    // ********************
    // Clock and timeout
    // ********************

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
            $display("Run timed out after %0d cycles without finishing the tests", cycle_count);
            $display("Verification failed");
            $finish;
        end
    end

    // ********************
    // Stimulus
    // ********************

    // Word i of a fill line is the seed plus i.
    function automatic logic [LINE_BITS-1:0] expand_line(input logic [WORD_BITS-1:0] seed);
        logic [LINE_BITS-1:0] line_val;
        for (int i = 0; i < LINE_WORDS; i++) begin
            line_val[i*WORD_BITS +: WORD_BITS] = seed + WORD_BITS'(i);
        end
        return line_val;
    endfunction

    task automatic load_tests();
        int                    fd;
        int                    count;
        int                    f_op;
        int                    f_mask;
        int                    f_hit;
        int                    f_vvalid;
        int                    f_vdirty;
        logic [ADDR_WIDTH-1:0] f_addr;
        logic [WORD_BITS-1:0]  f_wdata;
        logic [WORD_BITS-1:0]  f_rdata;
        logic [ADDR_WIDTH-1:0] f_vaddr;
        string                 text;
        test_t                 t;
        fd = $fopen("sim/cache_stim.txt", "r");
        if (fd == 0) begin
            $display("Cannot open the stimulus file sim/cache_stim.txt");
            load_error = 1'b1;
            return;
        end
        while ($fgets(text, fd) > 0) begin
            if (text[0] != "#") begin
                count = $sscanf(text, "%h %h %h %h %h %h %h %h %h", f_op, f_addr, f_wdata,
                                f_mask, f_hit, f_rdata, f_vvalid, f_vdirty, f_vaddr);
                if (count == 9) begin
                    t.op     = cache_pkg::op_e'(f_op[1:0]);
                    t.addr   = f_addr;
                    t.wdata  = f_wdata;
                    t.mask   = f_mask[cache_pkg::WORD_BYTES-1:0];
                    t.hit    = f_hit[0];
                    t.rdata  = f_rdata;
                    t.vvalid = f_vvalid[0];
                    t.vdirty = f_vdirty[0];
                    t.vaddr  = f_vaddr;
                    tests.push_back(t);
                end else if (count > 0) begin
                    $display("Malformed line in the stimulus file: %s", text);
                    load_error = 1'b1;
                end
            end
        end
        $fclose(fd);
    endtask

    // Called one step after a rising edge; returns one step after the accepting edge.
    task automatic drive_test(input test_t t);
        while (!ready) begin
            @(posedge clk);
            #1;
        end
        req        = 1'b1;
        op         = t.op;
        addr       = t.addr;
        wdata      = t.wdata;
        wmask      = t.mask;
        fill_line  = expand_line(t.wdata);
        exp_op     = t.op;
        exp_addr   = t.addr;
        exp_hit    = t.hit;
        exp_data   = t.rdata;
        exp_vvalid = t.vvalid;
        exp_vdirty = t.vdirty;
        exp_vaddr  = t.vaddr;
        @(posedge clk);
        #1;
        req = 1'b0;
    endtask

    initial begin
        clk         = 1'b0;
        rst_n       = 1'b0;
        req         = 1'b0;
        op          = cache_pkg::OP_READ;
        addr        = '0;
        wdata       = '0;
        wmask       = '0;
        fill_line   = '0;
        exp_op      = cache_pkg::OP_READ;
        exp_addr    = '0;
        exp_hit     = 1'b0;
        exp_data    = '0;
        exp_vvalid  = 1'b0;
        exp_vdirty  = 1'b0;
        exp_vaddr   = '0;
        cycle_count = 0;
        cycle_limit = 0;
        load_error  = 1'b0;
        load_tests();
        if (load_error || tests.size() == 0) begin
            $display("No usable tests could be read from the stimulus file");
            $display("Verification failed");
            $finish;
        end else begin
            cycle_limit = 4 * tests.size() + RESET_CYCLES + 20;
            repeat (RESET_CYCLES) @(posedge clk);
            #1;
            rst_n = 1'b1;
            foreach (tests[i]) begin
                drive_test(tests[i]);
            end
            // The last response arrives before the next edge.
            repeat (2) @(posedge clk);
            #1;
            $display("Tests: %0d  passed: %0d  failed: %0d", tests.size(), pass_count,
                     fail_count);
            if (fail_count == 0 && resp_count == tests.size()) begin
                $display("Verification passed");
            end else begin
                if (resp_count != tests.size()) begin
                    $display("Only %0d of %0d commands received a response", resp_count,
                             tests.size());
                end
                $display("Verification failed");
            end
            $finish;
        end
    end

endmodule

// File: sim/cache_stim.txt
# op(0 read,1 write,2 fill) addr wdata_or_seed mask hit rdata victim_valid victim_dirty victim_addr
# All hex. hit is ignored for fills; rdata is checked on read hits and on valid victims.
0 00000000 00000000 0 0 00000000 0 0 00000000
0 12345040 00000000 0 0 00000000 0 0 00000000
0 00000FFC 00000000 0 0 00000000 0 0 00000000
1 00000100 AABBCCDD F 0 00000000 0 0 00000000
2 12345040 10000000 0 0 00000000 0 0 00000000
0 12345044 00000000 0 1 10000001 0 0 00000000
0 1234507C 00000000 0 1 1000000F 0 0 00000000
0 12345040 00000000 0 1 10000000 0 0 00000000
0 ABCDE040 00000000 0 0 00000000 0 0 00000000
1 12345048 AABBCCDD 5 1 00000000 0 0 00000000
0 12345048 00000000 0 1 10BB00DD 0 0 00000000
1 ABCDE04C FFFFFFFF F 0 00000000 0 0 00000000
0 1234504C 00000000 0 1 10000003 0 0 00000000
0 ABCDE04C 00000000 0 0 00000000 0 0 00000000
2 ABCDE048 20000000 0 0 10BB00DD 1 1 12345040
0 ABCDE048 00000000 0 1 20000002 0 0 00000000
0 12345048 00000000 0 0 00000000 0 0 00000000
2 55555050 30000000 0 0 20000004 1 0 ABCDE040
0 55555050 00000000 0 1 30000004 0 0 00000000
2 00000080 40000000 0 0 00000000 0 0 00000000
0 000000BC 00000000 0 1 4000000F 0 0 00000000
1 00000080 DEADBEEF F 1 00000000 0 0 00000000
1 00000084 11223344 8 1 00000000 0 0 00000000
0 00000084 00000000 0 1 11000001 0 0 00000000
0 00000080 00000000 0 1 DEADBEEF 0 0 00000000
2 7777708C 50000000 0 0 40000003 1 1 00000080
2 00000080 60000000 0 0 50000000 1 0 77777080
0 000000A0 00000000 0 1 60000008 0 0 00000000
2 FFFFFFC0 70000000 0 0 00000000 0 0 00000000
0 FFFFFFFC 00000000 0 1 7000000F 0 0 00000000
1 FFFFFFF0 0000CAFE 3 1 00000000 0 0 00000000
0 FFFFFFF0 00000000 0 1 7000CAFE 0 0 00000000
2 00000FF0 00000000 0 0 7000CAFE 1 1 FFFFFFC0
0 00000FF0 00000000 0 1 0000000C 0 0 00000000
0 FFFFFFF0 00000000 0 0 00000000 0 0 00000000
2 00000100 80000000 0 0 00000000 0 0 00000000
0 00000104 00000000 0 1 80000001 0 0 00000000

// File: vlog.f
src/cache_pkg.sv
src/cache_array.sv
src/cache_decode.sv
src/cache_execute.sv
src/cache_result.sv
src/cache_core.sv
sim/cache_assert.sv
sim/cache_checker.sv
sim/tb_cache.sv

// File: Makefile
VERILATOR = verilator
FLAGS     = --binary --assert -Wno-fatal -j 0
TOP       = tb_cache
FILELIST  = vlog.f
LOG       = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run $(TOP), check $(LOG) for a pass"
	@echo "  clean  remove the build directory and $(LOG)"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	-./obj_dir/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "Verification passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
